//--- rtl/z80_pkg.sv
package z80_pkg;

    // One byte on the memory bus or in a register
    typedef logic [7:0] data_t;

    // Memory address, program counter, stack pointer or register pair
    typedef logic [15:0] addr_t;

    // The 3-bit r field of an opcode
    typedef logic [2:0] reg_code_t;

    // The 2-bit dd or qq field of an opcode
    typedef logic [1:0] pair_code_t;

    // Instruction length in bytes, 1 to 3
    typedef logic [1:0] insn_len_t;

    // Instruction classes understood by the sequencer
    typedef enum logic [3:0] {
        GRP_NOP,
        GRP_LD_R_R,
        GRP_LD_R_N,
        GRP_LD_R_IND_HL,
        GRP_LD_IND_HL_R,
        GRP_LD_IND_HL_N,
        GRP_LD_DD_NN,
        GRP_LD_A_IND_NN,
        GRP_LD_IND_NN_A,
        GRP_PUSH_QQ,
        GRP_POP_QQ,
        GRP_EX_DE_HL,
        GRP_UNKNOWN
    } insn_group_t;

    // ST_FETCH collects the opcode and operand bytes.
    // The EXEC states each carry one memory access
    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC1,
        ST_EXEC2,
        ST_EXEC3
    } seq_state_t;

    // Pair code 3 means SP in the dd set and AF in the qq set
    typedef enum logic {
        PAIR_DD,
        PAIR_QQ
    } pair_set_t;

    localparam reg_code_t REG_A = 3'd7;

    // In an opcode this is (HL); the register file keeps F in this slot
    localparam reg_code_t REG_HL_IND = 3'd6;

    localparam pair_code_t PAIR_HL = 2'd2;
    localparam pair_code_t PAIR_SP = 2'd3;

endpackage

//--- rtl/z80_decoder.sv
`timescale 1ns/1ps

module z80_decoder (
    input  z80_pkg::data_t       opcode,
    output z80_pkg::insn_group_t group,
    output z80_pkg::insn_len_t   len
);

    import z80_pkg::*;

    reg_code_t dst;
    reg_code_t src;

    assign dst = opcode[5:3];
    assign src = opcode[2:0];

    // Classify by the top two bits first, then by the r and dd fields
    always_comb begin
        group = GRP_UNKNOWN;
        case (opcode[7:6])
            2'b00: begin
                if (opcode == 8'h00) begin
                    group = GRP_NOP;
                end else if (src == 3'b110) begin
                    if (dst == REG_HL_IND) begin
                        group = GRP_LD_IND_HL_N;
                    end else begin
                        group = GRP_LD_R_N;
                    end
                end else if (opcode[3:0] == 4'b0001) begin
                    group = GRP_LD_DD_NN;
                end else if (opcode == 8'h3a) begin
                    group = GRP_LD_A_IND_NN;
                end else if (opcode == 8'h32) begin
                    group = GRP_LD_IND_NN_A;
                end
            end
            2'b01: begin
                // 76h is HALT, which is not executed here
                if (dst == REG_HL_IND && src == REG_HL_IND) begin
                    group = GRP_UNKNOWN;
                end else if (dst == REG_HL_IND) begin
                    group = GRP_LD_IND_HL_R;
                end else if (src == REG_HL_IND) begin
                    group = GRP_LD_R_IND_HL;
                end else begin
                    group = GRP_LD_R_R;
                end
            end
            2'b11: begin
                if (opcode[3:0] == 4'b0101) begin
                    group = GRP_PUSH_QQ;
                end else if (opcode[3:0] == 4'b0001) begin
                    group = GRP_POP_QQ;
                end else if (opcode == 8'heb) begin
                    group = GRP_EX_DE_HL;
                end
            end
            default: begin
                group = GRP_UNKNOWN;
            end
        endcase
    end

    always_comb begin
        case (group)
            GRP_LD_R_N,
            GRP_LD_IND_HL_N: begin
                len = 2'd2;
            end
            GRP_LD_DD_NN,
            GRP_LD_A_IND_NN,
            GRP_LD_IND_NN_A: begin
                len = 2'd3;
            end
            default: begin
                len = 2'd1;
            end
        endcase
    end

endmodule

//--- rtl/z80_registers.sv
`timescale 1ns/1ps

module z80_registers (
    input  logic                  clk,
    input  logic                  reset,
    input  z80_pkg::reg_code_t    rd_code,
    output z80_pkg::data_t        rd_data,
    input  z80_pkg::pair_code_t   pair_rd,
    input  z80_pkg::pair_set_t    pair_set,
    output z80_pkg::addr_t        pair_data,
    input  logic                  wr8_en,
    input  z80_pkg::reg_code_t    wr8_code,
    input  z80_pkg::data_t        wr8_data,
    input  logic                  wr16_en,
    input  z80_pkg::pair_code_t   wr16_code,
    input  z80_pkg::pair_set_t    wr16_set,
    input  z80_pkg::addr_t        wr16_data,
    input  logic                  ex_de_hl
);

    import z80_pkg::*;

    localparam reg_code_t IDX_B = 3'd0;
    localparam reg_code_t IDX_C = 3'd1;
    localparam reg_code_t IDX_D = 3'd2;
    localparam reg_code_t IDX_E = 3'd3;
    localparam reg_code_t IDX_H = 3'd4;
    localparam reg_code_t IDX_L = 3'd5;

    // Indexed by the r field; slot 6 holds F since (HL) is never a register
    data_t regs [8];
    addr_t sp;

    assign rd_data = regs[rd_code];

    always_comb begin
        case (pair_rd)
            2'd0: pair_data = {regs[IDX_B], regs[IDX_C]};
            2'd1: pair_data = {regs[IDX_D], regs[IDX_E]};
            2'd2: pair_data = {regs[IDX_H], regs[IDX_L]};
            default: begin
                if (pair_set == PAIR_QQ) begin
                    pair_data = {regs[REG_A], regs[REG_HL_IND]};
                end else begin
                    pair_data = sp;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
            sp <= '0;
        end else begin
            if (ex_de_hl) begin
                regs[IDX_D] <= regs[IDX_H];
                regs[IDX_E] <= regs[IDX_L];
                regs[IDX_H] <= regs[IDX_D];
                regs[IDX_L] <= regs[IDX_E];
            end
            if (wr16_en) begin
                case (wr16_code)
                    2'd0: {regs[IDX_B], regs[IDX_C]} <= wr16_data;
                    2'd1: {regs[IDX_D], regs[IDX_E]} <= wr16_data;
                    2'd2: {regs[IDX_H], regs[IDX_L]} <= wr16_data;
                    default: begin
                        if (wr16_set == PAIR_QQ) begin
                            {regs[REG_A], regs[REG_HL_IND]} <= wr16_data;
                        end else begin
                            sp <= wr16_data;
                        end
                    end
                endcase
            end
            if (wr8_en) begin
                regs[wr8_code] <= wr8_data;
            end
        end
    end

endmodule

//--- rtl/z80_sequencer.sv
`timescale 1ns/1ps

module z80_sequencer #(
    parameter z80_pkg::addr_t RESET_PC = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  z80_pkg::data_t        mem_data,
    output z80_pkg::addr_t        addr,
    output logic                  read_mem,
    output logic                  write_mem,
    output z80_pkg::data_t        write_data,
    output logic                  done,
    output z80_pkg::data_t        opcode,
    input  z80_pkg::insn_group_t  group,
    input  z80_pkg::insn_len_t    len,
    output z80_pkg::reg_code_t    rd_code,
    input  z80_pkg::data_t        rd_data,
    output z80_pkg::pair_code_t   pair_rd,
    output z80_pkg::pair_set_t    pair_set,
    input  z80_pkg::addr_t        pair_data,
    output logic                  wr8_en,
    output z80_pkg::reg_code_t    wr8_code,
    output z80_pkg::data_t        wr8_data,
    output logic                  wr16_en,
    output z80_pkg::pair_code_t   wr16_code,
    output z80_pkg::pair_set_t    wr16_set,
    output z80_pkg::addr_t        wr16_data,
    output logic                  ex_de_hl
);

    import z80_pkg::*;

    seq_state_t state;
    seq_state_t next_state;
    addr_t      pc;
    addr_t      next_pc;
    insn_len_t  fetch_cnt;
    insn_len_t  next_fetch_cnt;
    insn_len_t  byte_cnt;
    data_t      opcode_q;
    data_t      operand_lo;
    data_t      data_lo;

    addr_t      next_addr;
    logic       next_read_mem;
    logic       next_write_mem;
    data_t      next_write_data;
    logic       next_done;
    logic       finish;

    pair_code_t qq;
    reg_code_t  qq_hi_code;

    // The first byte goes to the decoder straight from the bus
    assign opcode = (state == ST_FETCH && fetch_cnt == 2'd0) ? mem_data : opcode_q;
    assign byte_cnt = fetch_cnt + 2'd1;

    // The high byte of a qq pair is A when the pair is AF
    assign qq = opcode[5:4];
    assign qq_hi_code = (qq == PAIR_SP) ? REG_A : {qq, 1'b0};

    always_comb begin
        next_state = state;
        next_pc = pc;
        next_fetch_cnt = fetch_cnt;
        next_addr = addr;
        next_read_mem = 1'b0;
        next_write_mem = 1'b0;
        next_write_data = '0;
        next_done = 1'b0;
        finish = 1'b0;

        rd_code = opcode[2:0];
        pair_rd = PAIR_HL;
        pair_set = PAIR_DD;
        wr8_en = 1'b0;
        wr8_code = opcode[5:3];
        wr8_data = mem_data;
        wr16_en = 1'b0;
        wr16_code = opcode[5:4];
        wr16_set = PAIR_DD;
        wr16_data = {mem_data, operand_lo};
        ex_de_hl = 1'b0;

        case (state)
            ST_FETCH: begin
                next_pc = pc + 16'd1;
                next_addr = pc + 16'd1;
                next_read_mem = 1'b1;
                if (byte_cnt == len) begin
                    next_fetch_cnt = '0;
                    case (group)
                        GRP_LD_R_R: begin
                            wr8_en = 1'b1;
                            wr8_data = rd_data;
                            finish = 1'b1;
                        end
                        GRP_LD_R_N: begin
                            wr8_en = 1'b1;
                            finish = 1'b1;
                        end
                        GRP_LD_DD_NN: begin
                            wr16_en = 1'b1;
                            finish = 1'b1;
                        end
                        GRP_EX_DE_HL: begin
                            ex_de_hl = 1'b1;
                            finish = 1'b1;
                        end
                        GRP_LD_R_IND_HL: begin
                            next_addr = pair_data;
                            next_state = ST_EXEC1;
                        end
                        GRP_LD_IND_HL_R: begin
                            next_addr = pair_data;
                            next_read_mem = 1'b0;
                            next_write_mem = 1'b1;
                            next_write_data = rd_data;
                            next_state = ST_EXEC1;
                        end
                        GRP_LD_IND_HL_N: begin
                            next_addr = pair_data;
                            next_read_mem = 1'b0;
                            next_write_mem = 1'b1;
                            next_write_data = mem_data;
                            next_state = ST_EXEC1;
                        end
                        GRP_LD_A_IND_NN: begin
                            next_addr = {mem_data, operand_lo};
                            next_state = ST_EXEC1;
                        end
                        GRP_LD_IND_NN_A: begin
                            rd_code = REG_A;
                            next_addr = {mem_data, operand_lo};
                            next_read_mem = 1'b0;
                            next_write_mem = 1'b1;
                            next_write_data = rd_data;
                            next_state = ST_EXEC1;
                        end
                        GRP_PUSH_QQ: begin
                            // High byte goes first, at SP-1
                            pair_rd = PAIR_SP;
                            rd_code = qq_hi_code;
                            next_addr = pair_data - 16'd1;
                            next_read_mem = 1'b0;
                            next_write_mem = 1'b1;
                            next_write_data = rd_data;
                            next_state = ST_EXEC1;
                        end
                        GRP_POP_QQ: begin
                            pair_rd = PAIR_SP;
                            next_addr = pair_data;
                            next_state = ST_EXEC1;
                        end
                        default: begin
                            finish = 1'b1;
                        end
                    endcase
                end else begin
                    next_fetch_cnt = fetch_cnt + 2'd1;
                end
            end
            ST_EXEC1: begin
                case (group)
                    GRP_LD_R_IND_HL: begin
                        wr8_en = 1'b1;
                        finish = 1'b1;
                    end
                    GRP_LD_A_IND_NN: begin
                        wr8_en = 1'b1;
                        wr8_code = REG_A;
                        finish = 1'b1;
                    end
                    GRP_PUSH_QQ: begin
                        // Low byte comes from the pair read, with AF in slot 3
                        pair_rd = qq;
                        pair_set = PAIR_QQ;
                        next_addr = addr - 16'd1;
                        next_write_mem = 1'b1;
                        next_write_data = pair_data[7:0];
                        next_state = ST_EXEC2;
                    end
                    GRP_POP_QQ: begin
                        pair_rd = PAIR_SP;
                        wr16_en = 1'b1;
                        wr16_code = PAIR_SP;
                        wr16_data = pair_data + 16'd2;
                        next_addr = addr + 16'd1;
                        next_read_mem = 1'b1;
                        next_state = ST_EXEC2;
                    end
                    default: begin
                        // The single memory write has gone out
                        finish = 1'b1;
                    end
                endcase
            end
            ST_EXEC2: begin
                if (group == GRP_POP_QQ) begin
                    wr16_en = 1'b1;
                    wr16_set = PAIR_QQ;
                    wr16_data = {mem_data, data_lo};
                end else if (group == GRP_PUSH_QQ) begin
                    pair_rd = PAIR_SP;
                    wr16_en = 1'b1;
                    wr16_code = PAIR_SP;
                    wr16_data = pair_data - 16'd2;
                end
                finish = 1'b1;
            end
            default: begin
                // ST_EXEC3 is never entered; fall back to fetching
                finish = 1'b1;
            end
        endcase

        if (finish) begin
            next_done = 1'b1;
            next_addr = next_pc;
            next_read_mem = 1'b1;
            next_write_mem = 1'b0;
            next_write_data = '0;
            next_state = ST_FETCH;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_FETCH;
            pc <= RESET_PC;
            fetch_cnt <= '0;
            addr <= RESET_PC;
            read_mem <= 1'b1;
            write_mem <= 1'b0;
            write_data <= '0;
            done <= 1'b0;
        end else begin
            state <= next_state;
            pc <= next_pc;
            fetch_cnt <= next_fetch_cnt;
            addr <= next_addr;
            read_mem <= next_read_mem;
            write_mem <= next_write_mem;
            write_data <= next_write_data;
            done <= next_done;
        end
    end

    // Opcode, low operand byte and the low byte of a POP
    always_ff @(posedge clk) begin
        if (state == ST_FETCH && fetch_cnt == 2'd0) begin
            opcode_q <= mem_data;
        end
        if (state == ST_FETCH && fetch_cnt == 2'd1) begin
            operand_lo <= mem_data;
        end
        if (state == ST_EXEC1) begin
            data_lo <= mem_data;
        end
    end

endmodule

//--- rtl/z80_core.sv
`timescale 1ns/1ps

module z80_core #(
    parameter z80_pkg::addr_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  z80_pkg::data_t  mem_data,
    output z80_pkg::addr_t  addr,
    output logic            read_mem,
    output logic            write_mem,
    output z80_pkg::data_t  write_data,
    output logic            done
);

    import z80_pkg::*;

    data_t       opcode;
    insn_group_t group;
    insn_len_t   len;

    reg_code_t   rd_code;
    data_t       rd_data;
    pair_code_t  pair_rd;
    pair_set_t   pair_set;
    addr_t       pair_data;
    logic        wr8_en;
    reg_code_t   wr8_code;
    data_t       wr8_data;
    logic        wr16_en;
    pair_code_t  wr16_code;
    pair_set_t   wr16_set;
    addr_t       wr16_data;
    logic        ex_de_hl;

    z80_sequencer #(
        .RESET_PC(RESET_PC)
    ) i_z80_sequencer (
        .clk(clk),
        .reset(reset),
        .mem_data(mem_data),
        .addr(addr),
        .read_mem(read_mem),
        .write_mem(write_mem),
        .write_data(write_data),
        .done(done),
        .opcode(opcode),
        .group(group),
        .len(len),
        .rd_code(rd_code),
        .rd_data(rd_data),
        .pair_rd(pair_rd),
        .pair_set(pair_set),
        .pair_data(pair_data),
        .wr8_en(wr8_en),
        .wr8_code(wr8_code),
        .wr8_data(wr8_data),
        .wr16_en(wr16_en),
        .wr16_code(wr16_code),
        .wr16_set(wr16_set),
        .wr16_data(wr16_data),
        .ex_de_hl(ex_de_hl)
    );

    z80_decoder i_z80_decoder (
        .opcode(opcode),
        .group(group),
        .len(len)
    );

    z80_registers i_z80_registers (
        .clk(clk),
        .reset(reset),
        .rd_code(rd_code),
        .rd_data(rd_data),
        .pair_rd(pair_rd),
        .pair_set(pair_set),
        .pair_data(pair_data),
        .wr8_en(wr8_en),
        .wr8_code(wr8_code),
        .wr8_data(wr8_data),
        .wr16_en(wr16_en),
        .wr16_code(wr16_code),
        .wr16_set(wr16_set),
        .wr16_data(wr16_data),
        .ex_de_hl(ex_de_hl)
    );

endmodule

//--- test/z80_mem_model.sv
`timescale 1ns/1ps

module z80_mem_model (
    input  logic            clk,
    input  z80_pkg::addr_t  addr,
    input  logic            read_mem,
    input  logic            write_mem,
    input  z80_pkg::data_t  write_data,
    output z80_pkg::data_t  mem_data
);

    import z80_pkg::*;

    localparam int LOG_DEPTH = 64;

    data_t mem [65536];
    addr_t log_addr [LOG_DEPTH];
    data_t log_data [LOG_DEPTH];
    int    log_count;
    int    clash_count;

    // Reads answer in the same cycle as the address
    assign mem_data = mem[addr];

    always @(posedge clk) begin
        if (write_mem) begin
            mem[addr] <= write_data;
            if (log_count < LOG_DEPTH) begin
                log_addr[log_count] <= addr;
                log_data[log_count] <= write_data;
            end
            log_count <= log_count + 1;
        end
        if (read_mem && write_mem) begin
            clash_count <= clash_count + 1;
        end
    end

    // Background pattern, so that a stray read is easy to spot
    task automatic fill();
        for (int a = 0; a < 65536; a++) begin
            mem[a] = data_t'(a[15:8] ^ a[7:0] ^ 8'h5a);
        end
    endtask

    task automatic write_byte(input addr_t a, input data_t d);
        mem[a] = d;
    endtask

    task automatic clear_log();
        log_count = 0;
        clash_count = 0;
    endtask

endmodule

//--- test/z80_core_tb.sv
`timescale 1ns/1ps

module z80_core_tb;

    import z80_pkg::*;

    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 5;

    // Worst case per instruction is three fetch cycles and one access
    localparam int NUM_TESTS = 9;
    localparam int NUM_INSNS = 55;
    localparam int WORST_INSN_CYCLES = 4;
    localparam int TIMEOUT_CYCLES =
        4 * (NUM_TESTS * (RESET_CYCLES + 1) + NUM_INSNS * WORST_INSN_CYCLES);

    localparam data_t OP_NOP = 8'h00;
    localparam data_t OP_HALT = 8'h76;
    localparam data_t OP_LD_BC_NN = 8'h01;
    localparam data_t OP_LD_DE_NN = 8'h11;
    localparam data_t OP_LD_HL_NN = 8'h21;
    localparam data_t OP_LD_SP_NN = 8'h31;
    localparam data_t OP_LD_IND_HL_N = 8'h36;
    localparam data_t OP_LD_A_IND_NN = 8'h3a;
    localparam data_t OP_LD_IND_NN_A = 8'h32;
    localparam data_t OP_PUSH_BC = 8'hc5;
    localparam data_t OP_PUSH_DE = 8'hd5;
    localparam data_t OP_POP_DE = 8'hd1;
    localparam data_t OP_EX_DE_HL = 8'heb;

    localparam reg_code_t R_B = 3'd0;
    localparam reg_code_t R_C = 3'd1;
    localparam reg_code_t R_D = 3'd2;
    localparam reg_code_t R_E = 3'd3;
    localparam reg_code_t R_H = 3'd4;
    localparam reg_code_t R_L = 3'd5;

    logic  clk;
    logic  reset;
    data_t mem_data;
    addr_t addr;
    logic  read_mem;
    logic  write_mem;
    data_t write_data;
    logic  done;

    int     errors;
    int     tests_run;
    int     tests_failed;
    int     cycles;
    integer seed;
    addr_t  prog_addr;
    addr_t  done_addr [64];
    int     done_count;

    z80_core i_z80_core (
        .clk(clk),
        .reset(reset),
        .mem_data(mem_data),
        .addr(addr),
        .read_mem(read_mem),
        .write_mem(write_mem),
        .write_data(write_data),
        .done(done)
    );

    z80_mem_model i_mem (
        .clk(clk),
        .addr(addr),
        .read_mem(read_mem),
        .write_mem(write_mem),
        .write_data(write_data),
        .mem_data(mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic data_t encode_ld_r_n(input reg_code_t r);
        return {2'b00, r, 3'b110};
    endfunction

    function automatic data_t encode_ld_r_r(input reg_code_t dst, input reg_code_t src);
        return {2'b01, dst, src};
    endfunction

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t actual, input addr_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, actual, expected);
            errors++;
        end
    endtask

    // The DUT sits in reset while its memory is rewritten
    task automatic start_program();
        reset = 1'b1;
        i_mem.fill();
        i_mem.clear_log();
        prog_addr = '0;
    endtask

    task automatic emit(input data_t b);
        i_mem.write_byte(prog_addr, b);
        prog_addr = prog_addr + 16'd1;
    endtask

    task automatic emit_word(input addr_t w);
        emit(w[7:0]);
        emit(w[15:8]);
    endtask

    task automatic release_reset();
        repeat (RESET_CYCLES) step();
        reset = 1'b0;
    endtask

    task automatic wait_for_dones(input int n);
        done_count = 0;
        while (done_count < n) begin
            step();
            if (done) begin
                done_addr[done_count] = addr;
                check_flag("read_mem with done", read_mem, 1'b1);
                done_count++;
            end
        end
    endtask

    task automatic run_program(input int n_insns);
        release_reset();
        wait_for_dones(n_insns);
    endtask

    task automatic expect_write_count(input int n);
        if (i_mem.log_count != n) begin
            $display("ERROR at %0t: %0d memory writes logged where %0d were expected",
                     $time, i_mem.log_count, n);
            errors++;
        end
    endtask

    task automatic expect_write(input int idx, input addr_t a, input data_t d);
        if (idx >= i_mem.log_count) begin
            $display("ERROR at %0t: memory write %0d never happened", $time, idx);
            errors++;
        end else begin
            check_addr($sformatf("write %0d addr", idx), i_mem.log_addr[idx], a);
            check_data($sformatf("write %0d data", idx), i_mem.log_data[idx], d);
        end
    endtask

    task automatic report_test(input string name, input int base);
        if (i_mem.clash_count != 0) begin
            $display("ERROR at %0t: read_mem and write_mem were high in the same cycle", $time);
            errors++;
        end
        tests_run++;
        if (errors == base) begin
            $display("%-12s ok", name);
        end else begin
            tests_failed++;
            $display("%-12s %0d check(s) wrong", name, errors - base);
        end
    endtask

    task automatic test_reset();
        int base;
        base = errors;
        start_program();
        emit(OP_NOP);
        release_reset();
        check_addr("addr", addr, 16'h0000);
        check_flag("read_mem", read_mem, 1'b1);
        check_flag("write_mem", write_mem, 1'b0);
        check_flag("done", done, 1'b0);
        check_data("write_data", write_data, 8'h00);
        report_test("reset", base);
    endtask

    task automatic test_byte_loads();
        int    base;
        data_t n;
        base = errors;
        n = 8'h5a;
        start_program();
        emit(encode_ld_r_n(R_B));
        emit(n);
        emit(encode_ld_r_r(REG_A, R_B));
        emit(OP_LD_IND_NN_A);
        emit_word(16'h8123);
        run_program(3);
        expect_write_count(1);
        expect_write(0, 16'h8123, n);
        report_test("byte_loads", base);
    endtask

    task automatic test_nop_unknown();
        int base;
        base = errors;
        start_program();
        emit(OP_NOP);
        emit(OP_HALT);
        run_program(2);
        expect_write_count(0);
        check_addr("addr after NOP", done_addr[0], 16'h0001);
        check_addr("addr after 76h", done_addr[1], 16'h0002);
        report_test("nop_unknown", base);
    endtask

    task automatic test_hl_store();
        int base;
        base = errors;
        start_program();
        emit(OP_LD_HL_NN);
        emit_word(16'h4567);
        emit(OP_LD_IND_HL_N);
        emit(8'ha5);
        run_program(2);
        expect_write_count(1);
        expect_write(0, 16'h4567, 8'ha5);
        report_test("hl_store", base);
    endtask

    task automatic test_hl_copy();
        int base;
        base = errors;
        start_program();
        i_mem.write_byte(16'h3000, 8'h9c);
        emit(OP_LD_HL_NN);
        emit_word(16'h3000);
        emit(encode_ld_r_r(R_C, REG_HL_IND));
        emit(OP_LD_HL_NN);
        emit_word(16'h3001);
        emit(encode_ld_r_r(REG_HL_IND, R_C));
        run_program(4);
        expect_write_count(1);
        expect_write(0, 16'h3001, 8'h9c);
        report_test("hl_copy", base);
    endtask

    task automatic test_nn_copy();
        int base;
        base = errors;
        start_program();
        i_mem.write_byte(16'h6000, 8'h3e);
        emit(OP_LD_A_IND_NN);
        emit_word(16'h6000);
        emit(OP_LD_IND_NN_A);
        emit_word(16'h6100);
        run_program(2);
        expect_write_count(1);
        expect_write(0, 16'h6100, 8'h3e);
        report_test("nn_copy", base);
    endtask

    // The final PUSH lands on the same slots only if POP restored SP
    task automatic test_stack();
        int    base;
        addr_t top;
        addr_t v;
        base = errors;
        top = 16'hf000;
        v = 16'h1234;
        start_program();
        emit(OP_LD_SP_NN);
        emit_word(top);
        emit(OP_LD_BC_NN);
        emit_word(v);
        emit(OP_PUSH_BC);
        emit(OP_POP_DE);
        emit(OP_LD_HL_NN);
        emit_word(16'h5000);
        emit(encode_ld_r_r(REG_HL_IND, R_D));
        emit(OP_LD_HL_NN);
        emit_word(16'h5001);
        emit(encode_ld_r_r(REG_HL_IND, R_E));
        emit(OP_PUSH_DE);
        run_program(9);
        expect_write_count(6);
        expect_write(0, top - 16'd1, v[15:8]);
        expect_write(1, top - 16'd2, v[7:0]);
        expect_write(2, 16'h5000, v[15:8]);
        expect_write(3, 16'h5001, v[7:0]);
        expect_write(4, top - 16'd1, v[15:8]);
        expect_write(5, top - 16'd2, v[7:0]);
        report_test("stack", base);
    endtask

    task automatic test_exchange();
        int    base;
        addr_t v1;
        addr_t v2;
        base = errors;
        v1 = 16'hbeef;
        v2 = 16'h1357;
        start_program();
        emit(OP_LD_DE_NN);
        emit_word(v1);
        emit(OP_LD_HL_NN);
        emit_word(v2);
        emit(OP_EX_DE_HL);
        emit(encode_ld_r_r(REG_A, R_H));
        emit(OP_LD_IND_NN_A);
        emit_word(16'h5200);
        emit(encode_ld_r_r(REG_A, R_L));
        emit(OP_LD_IND_NN_A);
        emit_word(16'h5201);
        emit(encode_ld_r_r(REG_A, R_D));
        emit(OP_LD_IND_NN_A);
        emit_word(16'h5202);
        run_program(9);
        expect_write_count(3);
        expect_write(0, 16'h5200, v1[15:8]);
        expect_write(1, 16'h5201, v1[7:0]);
        expect_write(2, 16'h5202, v2[15:8]);
        report_test("exchange", base);
    endtask

    // Each value goes through a different register on its way to A
    task automatic test_random();
        int        base;
        data_t     vals [8];
        reg_code_t rc;
        base = errors;
        start_program();
        for (int i = 0; i < 8; i++) begin
            vals[i] = data_t'($random(seed));
            rc = reg_code_t'(i);
            if (rc == REG_HL_IND) begin
                rc = REG_A;
            end
            emit(encode_ld_r_n(rc));
            emit(vals[i]);
            emit(encode_ld_r_r(REG_A, rc));
            emit(OP_LD_IND_NN_A);
            emit_word(addr_t'(16'h7000 + i));
        end
        run_program(24);
        expect_write_count(8);
        for (int i = 0; i < 8; i++) begin
            expect_write(i, addr_t'(16'h7000 + i), vals[i]);
        end
        check_addr("addr after last done", done_addr[23], prog_addr);
        report_test("random", base);
    endtask

    initial begin
        reset = 1'b1;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        seed = 42296;
        prog_addr = '0;

        test_reset();
        test_byte_loads();
        test_nop_unknown();
        test_hl_store();
        test_hl_copy();
        test_nn_copy();
        test_stack();
        test_exchange();
        test_random();

        $display("Summary: %0d tests run, %0d with errors, %0d checks wrong",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- z80_core.f
rtl/z80_pkg.sv
rtl/z80_decoder.sv
rtl/z80_registers.sv
rtl/z80_sequencer.sv
rtl/z80_core.sv
test/z80_mem_model.sv
test/z80_core_tb.sv
